//--- verilog/rvPkg.sv
package rvPkg;

    //////////////////////////////
    // widths
    localparam int xlen        = 32; // data word
    localparam int regAddrBits = 5;  // x0..x31

    //////////////////////////////
    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011, // lw
        opStore  = 7'b0100011, // sw
        opOp     = 7'b0110011, // register-register
        opOpImm  = 7'b0010011, // register-immediate
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opLui    = 7'b0110111
    } opcode_e;

    // alu operations
    typedef enum logic [3:0] {
        aluAdd = 4'b0000,
        aluSub = 4'b0001,
        aluAnd = 4'b0010,
        aluOr  = 4'b0011,
        aluXor = 4'b0100,
        aluSlt = 4'b0101, // signed compare, uses the subtractor
        aluSll = 4'b0110,
        aluSrl = 4'b0111,
        aluSra = 4'b1000
    } aluOp_e;

    // immediate formats
    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immJ = 3'b011,
        immU = 3'b100
    } immSel_e;

    // register write source, code 2'b11 unused
    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10
    } resultSel_e;

    // branch funct3 field
    typedef enum logic [2:0] {
        brEq  = 3'b000,
        brNe  = 3'b001,
        brLt  = 3'b100,
        brGe  = 3'b101,
        brLtu = 3'b110,
        brGeu = 3'b111
    } branchCond_e;

    //////////////////////////////
    // one instruction word, six format views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm11to0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] imm11to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm4to0;
            logic [6:0] opcode;
        } sType;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } bType;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } jType;
        struct packed {
            logic [19:0] imm31to12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } uType;
    } instr_u;

endpackage

//--- verilog/pcUnit.sv
`timescale 1ns/1ps

module pcUnit import rvPkg::*; #(
    parameter int imemAddrBits = 11
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            pcSel,    // taken branch or jump
    input  logic [xlen-1:0] pcTarget, // pc + imm from execute
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] pcPlus4
);

    logic [xlen-1:0] pcNext;

    assign pcPlus4 = pc + xlen'(4);
    assign pcNext  = pcSel ? pcTarget : pcPlus4;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0; // boot from address 0
        end else begin
            pc <= pcNext;
        end
    end

    //////////////////////////////
    // fetch address sanity

    // branch and jump offsets are even but must land on words
    pcAligned: assert property (
        @(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00
    ) else $error("pc not word aligned: %h", pc);

    // no fetch past the end of program memory
    pcInRange: assert property (
        @(posedge clk) disable iff (rst)
        (pc >> (imemAddrBits + 2)) == '0
    ) else $error("pc outside program memory: %h", pc);

endmodule

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import rvPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  instr_u                 instr,
    // register file
    output logic [regAddrBits-1:0] rs1,
    output logic [regAddrBits-1:0] rs2,
    output logic [regAddrBits-1:0] rd,
    output logic                   regWrite,
    output logic                   memWrite,
    output resultSel_e             resultSel,
    // execute
    output logic                   aluSrcImm,
    output aluOp_e                 aluOp,
    output logic                   branch,
    output logic                   jump,
    output branchCond_e            branchCond,
    output logic [xlen-1:0]        immExt
);

    opcode_e opcode;
    immSel_e immSel;
    logic    useFunct;    // alu op taken from funct3/funct7
    logic    forceSub;    // branches compare by subtracting
    logic    opcodeKnown;
    logic    funct7b5;

    assign opcode     = opcode_e'(instr.rType.opcode);
    assign funct7b5   = instr.rType.funct7[5];
    assign rs2        = instr.rType.rs2;
    assign rd         = instr.rType.rd;
    assign branchCond = branchCond_e'(instr.bType.funct3);

    // lui has immediate bits where rs1 sits, read x0 so the alu adds to zero
    assign rs1 = (opcode == opLui) ? '0 : instr.rType.rs1;

    //////////////////////////////
    // main decoder
    always_comb begin
        regWrite    = 1'b0;
        memWrite    = 1'b0;
        resultSel   = resAlu;
        aluSrcImm   = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        immSel      = immI;
        useFunct    = 1'b0;
        forceSub    = 1'b0;
        opcodeKnown = 1'b1;
        case (opcode)
            opLoad: begin
                regWrite  = 1'b1;
                resultSel = resMem;
                aluSrcImm = 1'b1; // address = rs1 + imm
            end
            opStore: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
                immSel    = immS;
            end
            opOp: begin
                regWrite = 1'b1;
                useFunct = 1'b1;
            end
            opOpImm: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                useFunct  = 1'b1;
            end
            opBranch: begin
                branch   = 1'b1;
                immSel   = immB;
                forceSub = 1'b1; // flags from rs1 - rs2
            end
            opJal: begin
                regWrite  = 1'b1;
                resultSel = resPcPlus4; // link value
                jump      = 1'b1;
                immSel    = immJ;
            end
            opLui: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                immSel    = immU;
            end
            default: opcodeKnown = 1'b0; // all writes stay off
        endcase
    end

    //////////////////////////////
    // alu operation select
    always_comb begin
        aluOp = aluAdd; // lw, sw, lui, jal
        if (forceSub) begin
            aluOp = aluSub;
        end else if (useFunct) begin
            case (instr.rType.funct3)
                3'b000:  aluOp = (funct7b5 && opcode == opOp) ? aluSub : aluAdd; // no subi
                3'b001:  aluOp = aluSll;
                3'b010:  aluOp = aluSlt;
                3'b100:  aluOp = aluXor;
                3'b101:  aluOp = funct7b5 ? aluSra : aluSrl; // srai carries bit 30 too
                3'b110:  aluOp = aluOr;
                3'b111:  aluOp = aluAnd;
                default: aluOp = aluAdd; // sltu not supported
            endcase
        end
    end

    //////////////////////////////
    // immediate extension, sign from bit 31
    always_comb begin
        case (immSel)
            immI: immExt = {{20{instr.iType.imm11to0[11]}}, instr.iType.imm11to0};
            immS: immExt = {{20{instr.sType.imm11to5[6]}}, instr.sType.imm11to5,
                            instr.sType.imm4to0};
            immB: immExt = {{20{instr.bType.imm12}}, instr.bType.imm11,
                            instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
            immJ: immExt = {{12{instr.jType.imm20}}, instr.jType.imm19to12,
                            instr.jType.imm11, instr.jType.imm10to1, 1'b0};
            immU: immExt = {instr.uType.imm31to12, 12'b0};
            default: immExt = '0;
        endcase
    end

    // program fetched from memory must only hold the supported subset
    opcodeSupported: assert property (
        @(posedge clk) disable iff (rst)
        opcodeKnown
    ) else $error("unsupported opcode %b", instr.rType.opcode);

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ps

module regFile import rvPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [regAddrBits-1:0] rs1,
    input  logic [regAddrBits-1:0] rs2,
    input  logic [regAddrBits-1:0] rd,
    input  logic                   regWrite,
    input  resultSel_e             resultSel,
    input  logic [xlen-1:0]        aluResult,
    input  logic [xlen-1:0]        dmemReadData,
    input  logic [xlen-1:0]        pcPlus4,
    output logic [xlen-1:0]        rd1,
    output logic [xlen-1:0]        rd2
);

    logic [xlen-1:0] regs [31:1]; // x0 has no storage
    logic [xlen-1:0] result;

    //////////////////////////////
    // writeback select
    always_comb begin
        case (resultSel)
            resAlu:     result = aluResult;
            resMem:     result = dmemReadData; // lw
            resPcPlus4: result = pcPlus4;      // jal link
            default:    result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && rd != '0) begin // writes to x0 dropped
            regs[rd] <= result;
        end
    end

    // combinational read ports
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

    // decoder must never request a write from the spare select code
    resultSelValid: assert property (
        @(posedge clk) disable iff (rst)
        regWrite |-> resultSel inside {resAlu, resMem, resPcPlus4}
    ) else $error("register write with unused result select %b", resultSel);

endmodule

//--- verilog/execUnit.sv
`timescale 1ns/1ps

module execUnit import rvPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rd1,
    input  logic [xlen-1:0] rd2,
    input  logic [xlen-1:0] immExt,
    input  logic            aluSrcImm,
    input  aluOp_e          aluOp,
    input  logic            branch,
    input  logic            jump,
    input  branchCond_e     branchCond,
    output logic [xlen-1:0] aluResult,
    output logic [xlen-1:0] pcTarget,
    output logic            pcSel
);

    logic [xlen-1:0] srcA;
    logic [xlen-1:0] srcB;
    logic [xlen-1:0] srcBMod;  // srcB, inverted when subtracting
    logic [xlen-1:0] sum;
    logic            subtract;
    logic            carry;
    logic            v;        // signed overflow
    logic            c;        // carry out, 1 means no borrow
    logic            n;        // negative
    logic            z;        // zero
    logic            condMet;

    //////////////////////////////
    // operands
    assign srcA = rd1;
    assign srcB = aluSrcImm ? immExt : rd2;

    // one adder for add, sub, slt and branch compares
    assign subtract      = (aluOp == aluSub) || (aluOp == aluSlt);
    assign srcBMod       = subtract ? ~srcB : srcB;
    assign {carry, sum}  = srcA + srcBMod + xlen'(subtract);

    // flags straight off the adder
    assign c = carry;
    assign n = sum[xlen-1];
    assign z = (sum == '0);
    // adder inputs agree in sign but the sum does not
    assign v = (srcA[xlen-1] ^ sum[xlen-1]) & ~(srcA[xlen-1] ^ srcBMod[xlen-1]);

    //////////////////////////////
    // alu
    always_comb begin
        case (aluOp)
            aluAdd,
            aluSub:  aluResult = sum;
            aluAnd:  aluResult = srcA & srcB;
            aluOr:   aluResult = srcA | srcB;
            aluXor:  aluResult = srcA ^ srcB;
            aluSlt:  aluResult = {{(xlen-1){1'b0}}, n ^ v}; // signed less than
            aluSll:  aluResult = srcA << srcB[4:0];
            aluSrl:  aluResult = srcA >> srcB[4:0];
            aluSra:  aluResult = $signed(srcA) >>> srcB[4:0];
            default: aluResult = '0;
        endcase
    end

    //////////////////////////////
    // branch check on rs1 - rs2 flags
    always_comb begin
        case (branchCond)
            brEq:    condMet = z;
            brNe:    condMet = ~z;
            brLt:    condMet = n ^ v;
            brGe:    condMet = ~(n ^ v);
            brLtu:   condMet = ~c;    // borrow
            brGeu:   condMet = c;
            default: condMet = 1'b0;
        endcase
    end

    assign pcTarget = pc + immExt;                // branch and jal share it
    assign pcSel    = (branch & condMet) | jump;

    // decoder only emits the nine defined operations
    aluOpDefined: assert property (
        @(posedge clk) disable iff (rst)
        aluOp inside {aluAdd, aluSub, aluAnd, aluOr, aluXor,
                      aluSlt, aluSll, aluSrl, aluSra}
    ) else $error("undefined alu operation %b", aluOp);

endmodule

//--- verilog/rvCore.sv
`timescale 1ns/1ps

module rvCore import rvPkg::*; #(
    parameter int imemAddrBits = 11 // word address width of program memory
) (
    input  logic                    clk,
    input  logic                    rst,
    // instruction memory, read combinationally
    input  logic [xlen-1:0]         imemData,
    output logic [imemAddrBits-1:0] imemAddr,
    // data memory
    input  logic [xlen-1:0]         dmemReadData,
    output logic                    dmemWrite,
    output logic [xlen-1:0]         dmemAddr,
    output logic [xlen-1:0]         dmemWriteData
);

    // fetch
    logic [xlen-1:0]        pc;
    logic [xlen-1:0]        pcPlus4;
    logic [xlen-1:0]        pcTarget;
    logic                   pcSel;

    // decode
    logic [regAddrBits-1:0] rs1;
    logic [regAddrBits-1:0] rs2;
    logic [regAddrBits-1:0] rd;
    logic                   regWrite;
    resultSel_e             resultSel;
    logic                   aluSrcImm;
    aluOp_e                 aluOp;
    logic [xlen-1:0]        immExt;
    logic                   branch;
    logic                   jump;
    branchCond_e            branchCond;

    // register read and execute
    logic [xlen-1:0]        rd1;
    logic [xlen-1:0]        rd2;
    logic [xlen-1:0]        aluResult;

    //////////////////////////////
    pcUnit #(.imemAddrBits(imemAddrBits)) pcUnit_i (
        .clk(clk), .rst(rst),
        .pcSel(pcSel), .pcTarget(pcTarget),
        .pc(pc), .pcPlus4(pcPlus4)
    );

    assign imemAddr = pc[imemAddrBits+1:2]; // word index, byte offset dropped

    instrDecoder instrDecoder_i (
        .clk(clk), .rst(rst), .instr(imemData),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .regWrite(regWrite), .memWrite(dmemWrite), .resultSel(resultSel),
        .aluSrcImm(aluSrcImm), .aluOp(aluOp),
        .branch(branch), .jump(jump), .branchCond(branchCond),
        .immExt(immExt)
    );

    regFile regFile_i (
        .clk(clk), .rst(rst),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .regWrite(regWrite), .resultSel(resultSel),
        .aluResult(aluResult), .dmemReadData(dmemReadData), .pcPlus4(pcPlus4),
        .rd1(rd1), .rd2(rd2)
    );

    execUnit execUnit_i (
        .clk(clk), .rst(rst),
        .pc(pc), .rd1(rd1), .rd2(rd2), .immExt(immExt),
        .aluSrcImm(aluSrcImm), .aluOp(aluOp),
        .branch(branch), .jump(jump), .branchCond(branchCond),
        .aluResult(aluResult), .pcTarget(pcTarget), .pcSel(pcSel)
    );

    // memory side
    assign dmemAddr      = aluResult; // lw/sw address is rs1 + imm
    assign dmemWriteData = rd2;       // sw data straight from rs2

endmodule

//--- tests/rvProgramTable.svh
`ifndef RV_PROGRAM_TABLE_SVH
`define RV_PROGRAM_TABLE_SVH

//////////////////////////////
// program image, word 0 at byte address 0
// x1 = 12, x2 = 5, x3 = -7, x10 = store base 0x100
localparam int progLen = 56;

localparam logic [0:progLen-1][xlen-1:0] progWords = {
    32'h00C00093,                             // addi x1, x0, 12
    32'h00500113,                             // addi x2, x0, 5
    32'hFF900193,                             // addi x3, x0, -7
    32'h10000513,                             // addi x10, x0, 256
    // register-register ops, each result stored
    32'h00208233, 32'h00452023,               // add x4, x1, x2 ; sw x4, 0(x10)
    32'h40110233, 32'h00452223,               // sub x4, x2, x1 ; sw x4, 4(x10)
    32'h0020F233, 32'h00452423,               // and x4, x1, x2 ; sw x4, 8(x10)
    32'h0020E233, 32'h00452623,               // or x4, x1, x2 ; sw x4, 12(x10)
    32'h0020C233, 32'h00452823,               // xor x4, x1, x2 ; sw x4, 16(x10)
    32'h00112233, 32'h00452A23,               // slt x4, x2, x1 ; sw x4, 20(x10)
    // immediate ops on the negative operand
    32'h00419213, 32'h00452C23,               // slli x4, x3, 4 ; sw x4, 24(x10)
    32'h01C1D213, 32'h00452E23,               // srli x4, x3, 28 ; sw x4, 28(x10)
    32'h4011D213, 32'h02452023,               // srai x4, x3, 1 ; sw x4, 32(x10)
    32'hFFA1A213, 32'h02452223,               // slti x4, x3, -6 ; sw x4, 36(x10)
    32'hFFF0C213, 32'h02452423,               // xori x4, x1, -1 ; sw x4, 40(x10)
    // store, reload through a second base with negative offsets
    32'h04452023, 32'h08050593,               // sw x4, 64(x10) ; addi x11, x10, 128
    32'hFC05A283, 32'hFE55AC23,               // lw x5, -64(x11) ; sw x5, -8(x11)
    // not taken, then taken over a trap store to address 0
    32'h00208463, 32'h00108463, 32'h00302023, // beq x1 x2 then beq x1 x1
    32'h00211463, 32'h00209463, 32'h00302023, // bne x2 x2 then bne x1 x2
    32'h0020C463, 32'h0011C463, 32'h00302023, // blt x1 x2 then blt x3 x1
    32'h0021D463, 32'h0020D463, 32'h00302023, // bge x3 x2 then bge x1 x2
    32'h0021E463, 32'h00316463, 32'h00302023, // bltu x3 x2 then bltu x2 x3
    32'h00117463, 32'h0011F463, 32'h00302023, // bgeu x2 x1 then bgeu x3 x1
    // jump and link over one more trap
    32'h008004EF, 32'h00302023,               // jal x9, +8 ; sw x3, 0(x0)
    32'h02952623,                             // sw x9, 44(x10)
    32'h123456B7, 32'h02D52823,               // lui x13, 0x12345 ; sw x13, 48(x10)
    32'h04D00013, 32'h02052A23,               // addi x0, x0, 77 ; sw x0, 52(x10)
    32'h0000006F                              // jal x0, 0 end loop
};

//////////////////////////////
// expected stores in program order, {address, data}
localparam int storeCount = 16;

localparam logic [0:storeCount-1][2*xlen-1:0] expStores = {
    {32'h00000100, 32'h00000011}, // 12 + 5
    {32'h00000104, 32'hFFFFFFF9}, // 5 - 12
    {32'h00000108, 32'h00000004},
    {32'h0000010C, 32'h0000000D},
    {32'h00000110, 32'h00000009},
    {32'h00000114, 32'h00000001}, // 5 < 12
    {32'h00000118, 32'hFFFFFF90}, // -7 << 4
    {32'h0000011C, 32'h0000000F}, // logical, zeros shifted in
    {32'h00000120, 32'hFFFFFFFC}, // -7 >>> 1 rounds down
    {32'h00000124, 32'h00000001}, // -7 < -6
    {32'h00000128, 32'hFFFFFFF3}, // ~12
    {32'h00000140, 32'hFFFFFFF3},
    {32'h00000178, 32'hFFFFFFF3}, // reloaded word
    {32'h0000012C, 32'h000000C4}, // link of jal at 0xC0
    {32'h00000130, 32'h12345000},
    {32'h00000134, 32'h00000000}  // x0 ignored the write
};

`endif

//--- tests/rvCoreTb.sv
`timescale 1ns/1ps

module rvCoreTb import rvPkg::*; ();

    localparam int imemAddrBits = 11;
    localparam int dmemAddrBits = 8;  // 256 data words
    localparam int maxCycles    = 400;
    localparam int inputDelay   = 1;  // ns after the rising edge

    `include "rvProgramTable.svh"

    logic                    clk;
    logic                    rst;
    logic [xlen-1:0]         imemData;
    logic [imemAddrBits-1:0] imemAddr;
    logic [xlen-1:0]         dmemReadData;
    logic                    dmemWrite;
    logic [xlen-1:0]         dmemAddr;
    logic [xlen-1:0]         dmemWriteData;

    logic [xlen-1:0] imem [0:(1 << imemAddrBits)-1];
    logic [xlen-1:0] dmem [0:(1 << dmemAddrBits)-1];

    // store seen mid-cycle, committed after the edge
    logic            pendWe;
    logic [xlen-1:0] pendAddr;
    logic [xlen-1:0] pendData;

    int unsigned rngInit;
    int          errors;
    int          checks;
    int          storeIdx;
    int          cycles;
    bit          endReached;

    rvCore #(.imemAddrBits(imemAddrBits)) dut_i (
        .clk(clk), .rst(rst),
        .imemData(imemData), .imemAddr(imemAddr),
        .dmemReadData(dmemReadData), .dmemWrite(dmemWrite),
        .dmemAddr(dmemAddr), .dmemWriteData(dmemWriteData)
    );

    always #20 clk = ~clk; // 40 ns period

    //////////////////////////////
    // memory models, both read combinationally
    assign imemData     = imem[imemAddr];
    assign dmemReadData = dmem[dmemAddr[dmemAddrBits+1:2]];

    always begin
        @(negedge clk);
        pendWe   = dmemWrite;
        pendAddr = dmemAddr;
        pendData = dmemWriteData;
        @(posedge clk);
        #(inputDelay);
        if (pendWe) begin
            dmem[pendAddr[dmemAddrBits+1:2]] = pendData;
        end
    end

    task automatic loadMemories();
        for (int i = 0; i < (1 << dmemAddrBits); i++) begin
            dmem[i] = $urandom(); // junk in unwritten words
        end
        for (int i = 0; i < progLen; i++) begin
            imem[i] = progWords[i];
        end
    endtask

    // one store against the next table row
    task automatic checkStore(input int idx);
        logic [xlen-1:0] wantAddr;
        logic [xlen-1:0] wantData;
        wantAddr = expStores[idx][2*xlen-1:xlen];
        wantData = expStores[idx][xlen-1:0];
        checks++;
        assert (dmemAddr == wantAddr) else begin
            errors++;
            $display("FAIL dmemAddr: got %h expected %h (store %0d)", dmemAddr, wantAddr, idx);
        end
        checks++;
        assert (dmemWriteData == wantData) else begin
            errors++;
            $display("FAIL dmemWriteData: got %h expected %h (store %0d)",
                     dmemWriteData, wantData, idx);
        end
    endtask

    //////////////////////////////
    initial begin
        rngInit    = $urandom(32'hc9fd4a84);
        clk        = 1'b0;
        rst        = 1'b1;
        errors     = 0;
        checks     = 0;
        storeIdx   = 0;
        endReached = 1'b0;
        loadMemories();

        repeat (10) @(posedge clk);
        #(inputDelay);
        rst = 1'b0;

        // one instruction per cycle, sampled mid-cycle
        cycles = 0;
        while (!endReached && cycles < maxCycles) begin
            @(negedge clk);
            cycles++;
            if (dmemWrite) begin
                checks++;
                assert (storeIdx < storeCount) else begin
                    errors++;
                    $display("unexpected extra store to address %h", dmemAddr);
                end
                if (storeIdx < storeCount) begin
                    checkStore(storeIdx);
                end
                storeIdx++;
            end
            if (imemAddr == progLen - 1) begin
                endReached = 1'b1; // parked on jal x0, 0
            end
        end

        checks++;
        assert (endReached) else begin
            errors++;
            $display("program never reached its end loop within %0d cycles", maxCycles);
        end
        checks++;
        assert (storeIdx == storeCount) else begin
            errors++;
            $display("saw %0d stores where %0d were expected", storeIdx, storeCount);
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- rvCore.f
+incdir+tests
verilog/rvPkg.sv
verilog/pcUnit.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/rvCore.sv
tests/rvCoreTb.sv
